// File: source/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// on-chip RAM window
`define RAM_BASE 64'h0000_0000_8000_0000
`define RAM_WORDS 512
`define RAM_ADDR_W 9

// reduced PLIC, standard base
`define PLIC_BASE 64'h0000_0000_0c00_0000
`define PLIC_PENDING_OFS 64'h0000_0000_0000_1000
`define PLIC_ENABLE_OFS 64'h0000_0000_0000_2000
`define PLIC_CTX_ENABLE_STRIDE 64'h0000_0000_0000_0080
`define PLIC_CLAIM_OFS 64'h0000_0000_0020_0004
`define PLIC_CTX_CLAIM_STRIDE 64'h0000_0000_0000_1000

// the one wired source
`define IRQ_SOURCE_ID 1

`endif

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // shared by loads and stores, stores stop at LS_D
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_PLIC,
        REGION_NONE
    } region_e;

    typedef enum logic [2:0] {
        PENDING,
        ENABLE0,
        ENABLE1,
        CLAIM0,
        CLAIM1,
        NONE
    } plic_reg_e;

    // one RAM word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ram_word_u;

endpackage

`default_nettype wire

// File: source/bus_ifs.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

// word operations from the sequencer into the RAM
interface ram_port_if import bus_pkg::*; ();
    logic [`RAM_ADDR_W-1:0] word_addr;
    ram_word_u              wdata;
    logic [3:0]             byte_en;
    logic                   write;
    logic                   read;

    modport seq (output word_addr, wdata, byte_en, write, read);
    modport ram (input word_addr, wdata, byte_en, write, read);
endinterface

// tells the formatter what to do with the returned data
interface read_return_if import bus_pkg::*; ();
    logic     capture_lo;
    logic     capture_hi;
    ls_type_e ls_type;
    logic [1:0] byte_ofs;
    logic     clear;
    logic     plic_load;

    modport seq (output capture_lo, capture_hi, ls_type, byte_ofs, clear, plic_load);
    modport fmt (input capture_lo, capture_hi, ls_type, byte_ofs, clear, plic_load);
endinterface

// register access into the interrupt controller
interface plic_reg_if import bus_pkg::*; ();
    plic_reg_e   reg_sel;
    logic        write;
    logic        read;
    logic [31:0] wdata;
    logic [31:0] rdata;

    modport seq (output reg_sel, write, read, wdata, input rdata);
    modport ctrl (input reg_sel, write, read, wdata, output rdata);
endinterface

`default_nettype wire

// File: source/bus_access_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module bus_access_sequencer import bus_pkg::*; (
    input  logic        clock_slow,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_read_enable,
    input  logic        bus_write_enable,
    input  ls_type_e    bus_ls_type,
    output logic        bus_read_done,
    output logic        bus_write_done,
    ram_port_if.seq     ram_port,
    read_return_if.seq  ret_port,
    plic_reg_if.seq     plic_port
);
    logic [63:0]            ram_ofs;
    logic [63:0]            plic_ofs;
    region_e                region_d;
    region_e                region_q;
    plic_reg_e              plic_reg_d;
    plic_reg_e              plic_reg_q;
    ls_type_e               ls_q;
    logic [63:0]            wdata_q;
    logic [`RAM_ADDR_W-1:0] word_addr_q;
    logic [1:0]             byte_ofs_q;
    logic                   is_write_q;
    logic                   active;
    logic [1:0]             step;
    logic [1:0]             last_step;
    logic                   ram_op;
    logic                   capture_lo_q;
    logic                   capture_hi_q;
    ram_word_u              lane_word;

    assign ram_ofs  = bus_address - `RAM_BASE;
    assign plic_ofs = bus_address - `PLIC_BASE;

    always_comb begin
        case (plic_ofs)
            `PLIC_PENDING_OFS: plic_reg_d = PENDING;
            `PLIC_ENABLE_OFS: plic_reg_d = ENABLE0;
            `PLIC_ENABLE_OFS + `PLIC_CTX_ENABLE_STRIDE: plic_reg_d = ENABLE1;
            `PLIC_CLAIM_OFS: plic_reg_d = CLAIM0;
            `PLIC_CLAIM_OFS + `PLIC_CTX_CLAIM_STRIDE: plic_reg_d = CLAIM1;
            default: plic_reg_d = NONE;
        endcase
        // below RAM_BASE wraps to a large offset
        if (ram_ofs < 64'(4 * `RAM_WORDS)) begin
            region_d = REGION_RAM;
        end else if (plic_reg_d != NONE) begin
            region_d = REGION_PLIC;
        end else begin
            region_d = REGION_NONE;
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            active         <= 1'b0;
            step           <= 2'd0;
            last_step      <= 2'd0;
            is_write_q     <= 1'b0;
            region_q       <= REGION_NONE;
            plic_reg_q     <= NONE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            capture_lo_q   <= 1'b0;
            capture_hi_q   <= 1'b0;
        end else begin
            // RAM word shows up one cycle after its read strobe
            capture_lo_q <= ram_port.read && step == 2'd1;
            capture_hi_q <= ram_port.read && step == 2'd2;
            if (bus_read_enable || bus_write_enable) begin
                active     <= 1'b1;
                step       <= 2'd0;
                is_write_q <= bus_write_enable;
                region_q   <= region_d;
                plic_reg_q <= plic_reg_d;
                // one extra step for read latency, one for the second word
                if (region_d == REGION_RAM) begin
                    last_step <= 2'd1 + 2'(!bus_write_enable) + 2'(bus_ls_type == LS_D);
                end else begin
                    last_step <= 2'd1;
                end
                if (bus_write_enable) begin
                    bus_write_done <= 1'b0;
                end else begin
                    bus_read_done <= 1'b0;
                end
            end else if (active) begin
                if (step == last_step) begin
                    active <= 1'b0;
                    if (is_write_q) begin
                        bus_write_done <= 1'b1;
                    end else begin
                        bus_read_done <= 1'b1;
                    end
                end else begin
                    step <= step + 2'd1;
                end
            end
        end
    end

    // request payload, only meaningful while active
    always_ff @(posedge clock_slow) begin
        if (bus_read_enable || bus_write_enable) begin
            ls_q        <= bus_ls_type;
            wdata_q     <= bus_write_data;
            word_addr_q <= ram_ofs[`RAM_ADDR_W+1:2];
            byte_ofs_q  <= ram_ofs[1:0];
        end
    end

    // step 1 is the first word, step 2 the upper word of ld/sd
    assign ram_op = active && region_q == REGION_RAM
        && (step == 2'd1 || (ls_q == LS_D && step == 2'd2));

    always_comb begin
        if (step == 2'd2) begin
            lane_word = wdata_q[63:32];
            ram_port.byte_en = 4'b1111;
        end else begin
            case (ls_q)
                LS_B: begin
                    lane_word.bytes = {4{wdata_q[7:0]}};
                    ram_port.byte_en = 4'b0001 << byte_ofs_q;
                end
                LS_H: begin
                    lane_word.halves = {2{wdata_q[15:0]}};
                    ram_port.byte_en = byte_ofs_q[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    lane_word = wdata_q[31:0];
                    ram_port.byte_en = 4'b1111;
                end
            endcase
        end
    end

    assign ram_port.wdata     = lane_word;
    assign ram_port.word_addr = word_addr_q + `RAM_ADDR_W'(step == 2'd2);
    assign ram_port.read      = ram_op && !is_write_q;
    assign ram_port.write     = ram_op && is_write_q;

    assign plic_port.reg_sel = plic_reg_q;
    assign plic_port.wdata   = wdata_q[31:0];
    assign plic_port.read    = active && region_q == REGION_PLIC && !is_write_q && step == 2'd1;
    assign plic_port.write   = active && region_q == REGION_PLIC && is_write_q && step == 2'd1;

    assign ret_port.capture_lo = capture_lo_q;
    assign ret_port.capture_hi = capture_hi_q;
    assign ret_port.ls_type    = ls_q;
    assign ret_port.byte_ofs   = byte_ofs_q;
    // PLIC rdata is combinational, so load in the same cycle as the read
    assign ret_port.plic_load  = plic_port.read;
    assign ret_port.clear      = active && region_q == REGION_NONE && !is_write_q
        && step == 2'd1;

endmodule

`default_nettype wire

// File: source/word_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module word_ram import bus_pkg::*; (
    input  logic       clock_slow,
    ram_port_if.ram    ram_port,
    output ram_word_u  rdata
);
    ram_word_u mem [`RAM_WORDS];

    // block RAM style, byte lanes plus registered read
    always_ff @(posedge clock_slow) begin
        if (ram_port.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram_port.byte_en[lane]) begin
                    mem[ram_port.word_addr].bytes[lane] <= ram_port.wdata.bytes[lane];
                end
            end
        end
        if (ram_port.read) begin
            rdata <= mem[ram_port.word_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/load_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module load_formatter import bus_pkg::*; (
    input  logic        clock_slow,
    input  logic        KEY0,
    read_return_if.fmt  ret_port,
    input  ram_word_u   ram_rdata,
    input  logic [31:0] plic_rdata,
    output logic [63:0] bus_read_data
);
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [63:0] lo_val;

    assign byte_sel = ram_rdata.bytes[ret_port.byte_ofs];
    assign half_sel = ram_rdata.halves[ret_port.byte_ofs[1]];

    always_comb begin
        case (ret_port.ls_type)
            LS_B: lo_val = {{56{byte_sel[7]}}, byte_sel};
            LS_BU: lo_val = {56'd0, byte_sel};
            LS_H: lo_val = {{48{half_sel[15]}}, half_sel};
            LS_HU: lo_val = {48'd0, half_sel};
            LS_W: lo_val = {{32{ram_rdata[31]}}, ram_rdata};
            // lwu, and the low half of ld
            default: lo_val = {32'd0, ram_rdata};
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data <= 64'd0;
        end else if (ret_port.clear) begin
            bus_read_data <= 64'd0;
        end else if (ret_port.plic_load) begin
            bus_read_data <= {32'd0, plic_rdata};
        end else if (ret_port.capture_lo) begin
            bus_read_data <= lo_val;
        end else if (ret_port.capture_hi) begin
            bus_read_data[63:32] <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module interrupt_controller import bus_pkg::*; (
    input  logic     clock_slow,
    input  logic     KEY0,
    input  logic     irq_source,
    plic_reg_if.ctrl plic_port,
    output logic     meip_interrupt,
    output logic     msip_interrupt
);
    logic        irq_sync;
    logic        irq_prev;
    logic        pending;
    logic [31:0] enable [2];
    logic [31:0] claim_id [2];
    logic        claim_hit;

    // context 0 is machine, context 1 supervisor
    always_comb begin
        for (int ctx = 0; ctx < 2; ctx++) begin
            claim_id[ctx] = (pending && enable[ctx][`IRQ_SOURCE_ID]) ? `IRQ_SOURCE_ID : 32'd0;
        end
    end

    assign meip_interrupt = claim_id[0] != 32'd0;
    assign msip_interrupt = claim_id[1] != 32'd0;

    // a claim that returns 0 leaves pending alone
    assign claim_hit = plic_port.read
        && ((plic_port.reg_sel == CLAIM0 && meip_interrupt)
        || (plic_port.reg_sel == CLAIM1 && msip_interrupt));

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            irq_sync  <= 1'b0;
            irq_prev  <= 1'b0;
            pending   <= 1'b0;
            enable[0] <= 32'd0;
            enable[1] <= 32'd0;
        end else begin
            irq_sync <= irq_source;
            irq_prev <= irq_sync;
            if (irq_sync && !irq_prev) begin
                pending <= 1'b1;
            end else if (claim_hit) begin
                pending <= 1'b0;
            end
            if (plic_port.write && plic_port.reg_sel == ENABLE0) begin
                enable[0] <= plic_port.wdata;
            end
            if (plic_port.write && plic_port.reg_sel == ENABLE1) begin
                enable[1] <= plic_port.wdata;
            end
        end
    end

    always_comb begin
        case (plic_port.reg_sel)
            PENDING: plic_port.rdata = 32'(pending) << `IRQ_SOURCE_ID;
            ENABLE0: plic_port.rdata = enable[0];
            ENABLE1: plic_port.rdata = enable[1];
            CLAIM0: plic_port.rdata = claim_id[0];
            CLAIM1: plic_port.rdata = claim_id[1];
            default: plic_port.rdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem import bus_pkg::*; (
    input  logic        clock_slow,
    input  logic        KEY0,
    input  logic [63:0] bus_address,
    input  logic [63:0] bus_write_data,
    input  logic        bus_read_enable,
    input  logic        bus_write_enable,
    input  ls_type_e    bus_ls_type,
    output logic [63:0] bus_read_data,
    output logic        bus_read_done,
    output logic        bus_write_done,
    input  logic        irq_source,
    output logic        meip_interrupt,
    output logic        msip_interrupt
);
    ram_word_u ram_rdata;

    ram_port_if    ram_bus ();
    read_return_if ret_bus ();
    plic_reg_if    plic_bus ();

    bus_access_sequencer u_sequencer (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_port         (ram_bus.seq),
        .ret_port         (ret_bus.seq),
        .plic_port        (plic_bus.seq)
    );

    word_ram u_ram (
        .clock_slow (clock_slow),
        .ram_port   (ram_bus.ram),
        .rdata      (ram_rdata)
    );

    load_formatter u_formatter (
        .clock_slow    (clock_slow),
        .KEY0          (KEY0),
        .ret_port      (ret_bus.fmt),
        .ram_rdata     (ram_rdata),
        .plic_rdata    (plic_bus.rdata),
        .bus_read_data (bus_read_data)
    );

    interrupt_controller u_plic (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .irq_source     (irq_source),
        .plic_port      (plic_bus.ctrl),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clock_slow,
    output logic KEY0
);
    initial begin
        clock_slow = 1'b0;
        forever #(PERIOD_NS / 2) clock_slow = ~clock_slow;
    end

    // release away from the rising edge
    initial begin
        KEY0 = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_slow);
        @(negedge clock_slow);
        KEY0 = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/memory_subsystem_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module memory_subsystem_props import bus_pkg::*; (
    input logic        clock_slow,
    input logic        KEY0,
    input logic [63:0] bus_address,
    input logic        bus_read_enable,
    input logic        bus_write_enable,
    input ls_type_e    bus_ls_type,
    input logic        bus_read_done,
    input logic        bus_write_done,
    input logic        meip_interrupt,
    input logic        msip_interrupt,
    input logic        ram_read,
    input logic        ram_write
);
    int unsigned fail_count = 0;
    logic        was_reset;
    logic        busy;
    logic        busy_write;
    int unsigned wait_cycles;
    int unsigned limit;
    int unsigned req_limit;
    logic        in_ram;
    logic        done_now;

    assign in_ram   = (bus_address - `RAM_BASE) < 64'(4 * `RAM_WORDS);
    assign done_now = busy_write ? bus_write_done : bus_read_done;

    // cycles from the enable edge until done is back high
    always_comb begin
        if (!in_ram) begin
            req_limit = 2;
        end else if (bus_write_enable) begin
            req_limit = (bus_ls_type == LS_D) ? 3 : 2;
        end else begin
            req_limit = (bus_ls_type == LS_D) ? 4 : 3;
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            was_reset   <= 1'b1;
            busy        <= 1'b0;
            busy_write  <= 1'b0;
            wait_cycles <= 0;
            limit       <= 0;
        end else begin
            was_reset <= 1'b0;
            if (bus_read_enable || bus_write_enable) begin
                busy        <= 1'b1;
                busy_write  <= bus_write_enable;
                wait_cycles <= 0;
                limit       <= req_limit;
            end else if (busy) begin
                if (done_now) begin
                    busy <= 1'b0;
                end else begin
                    wait_cycles <= wait_cycles + 1;
                end
            end
        end
    end

    reset_state: assert property (@(posedge clock_slow)
        was_reset |-> bus_read_done && bus_write_done && !meip_interrupt
            && !msip_interrupt && !ram_read && !ram_write)
    else begin
        $error("outputs or RAM strobes not idle after reset");
        fail_count++;
    end

    read_done_falls: assert property (@(posedge clock_slow) disable iff (!KEY0)
        bus_read_enable |=> !bus_read_done)
    else begin
        $error("read done still high the cycle after the read enable");
        fail_count++;
    end

    write_done_falls: assert property (@(posedge clock_slow) disable iff (!KEY0)
        bus_write_enable |=> !bus_write_done)
    else begin
        $error("write done still high the cycle after the write enable");
        fail_count++;
    end

    done_in_time: assert property (@(posedge clock_slow) disable iff (!KEY0)
        busy && !done_now |-> wait_cycles < limit)
    else begin
        $error("done flag later than the access latency of %0d cycles", limit);
        fail_count++;
    end

    // a RAM strobe belongs to an open request of the same direction
    strobes_follow_request: assert property (@(posedge clock_slow) disable iff (!KEY0)
        (ram_read || ram_write) |-> busy && !(ram_read && ram_write)
            && ram_write == busy_write)
    else begin
        $error("RAM strobe outside a matching request or read and write together");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: testbench/memory_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module memory_subsystem_tb import bus_pkg::*; ();
    localparam int NUM_TESTS      = 5;
    localparam int MAX_REQUESTS   = 40;
    localparam int ACCESS_TIMEOUT = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int RAM_BYTES      = 4 * `RAM_WORDS;

    localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_4000_0000;
    localparam logic [63:0] PENDING_ADDR  = `PLIC_BASE + `PLIC_PENDING_OFS;
    localparam logic [63:0] ENABLE0_ADDR  = `PLIC_BASE + `PLIC_ENABLE_OFS;
    localparam logic [63:0] ENABLE1_ADDR  = ENABLE0_ADDR + `PLIC_CTX_ENABLE_STRIDE;
    localparam logic [63:0] CLAIM0_ADDR   = `PLIC_BASE + `PLIC_CLAIM_OFS;
    localparam logic [31:0] SOURCE_BIT    = 32'd1 << `IRQ_SOURCE_ID;

    logic        clock_slow;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_read_enable;
    logic        bus_write_enable;
    ls_type_e    bus_ls_type;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    logic        irq_source;
    logic        meip_interrupt;
    logic        msip_interrupt;

    // byte image of what the RAM should hold
    logic [7:0] model [RAM_BYTES];
    int         errors = 0;
    int         failed_tests = 0;
    int         test_start;
    string      test_name;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clock_slow (clock_slow),
        .KEY0       (KEY0)
    );

    memory_subsystem dut (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .irq_source       (irq_source),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    bind memory_subsystem memory_subsystem_props props (
        .clock_slow       (clock_slow),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt),
        .ram_read         (ram_bus.read),
        .ram_write        (ram_bus.write)
    );

    function automatic void check_value(string what, logic [63:0] expected,
                                        logic [63:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endfunction

    // little endian, extension picked by the load type
    function automatic logic [63:0] expect_load(int unsigned ofs, ls_type_e ls);
        logic [63:0] raw;
        raw = '0;
        for (int unsigned i = 0; i < 8; i++) begin
            raw[8*i +: 8] = model[11'(ofs + i)];
        end
        case (ls)
            LS_B: return {{56{raw[7]}}, raw[7:0]};
            LS_BU: return {56'd0, raw[7:0]};
            LS_H: return {{48{raw[15]}}, raw[15:0]};
            LS_HU: return {48'd0, raw[15:0]};
            LS_W: return {{32{raw[31]}}, raw[31:0]};
            LS_WU: return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    task automatic access(input logic is_write, input logic [63:0] addr, input ls_type_e ls,
                          input logic [63:0] wdata, output logic [63:0] rdata);
        int cycles;
        @(posedge clock_slow);
        bus_address      <= addr;
        bus_ls_type      <= ls;
        bus_write_data   <= wdata;
        bus_write_enable <= is_write;
        bus_read_enable  <= !is_write;
        @(posedge clock_slow);
        bus_write_enable <= 1'b0;
        bus_read_enable  <= 1'b0;
        cycles = 0;
        @(negedge clock_slow);
        while (!(is_write ? bus_write_done : bus_read_done) && cycles < ACCESS_TIMEOUT) begin
            @(negedge clock_slow);
            cycles++;
        end
        if (cycles >= ACCESS_TIMEOUT) begin
            $display("%s: done flag stayed low after the request to %h", test_name, addr);
            errors++;
        end
        rdata = bus_read_data;
    endtask

    task automatic store(input int unsigned ofs, input ls_type_e ls, input logic [63:0] data);
        int unsigned nbytes;
        logic [63:0] unused;
        case (ls)
            LS_B: nbytes = 1;
            LS_H: nbytes = 2;
            LS_W: nbytes = 4;
            default: nbytes = 8;
        endcase
        for (int unsigned i = 0; i < nbytes; i++) begin
            model[11'(ofs + i)] = data[8*i +: 8];
        end
        access(1'b1, `RAM_BASE + 64'(ofs), ls, data, unused);
    endtask

    task automatic load_check(input string what, input int unsigned ofs, input ls_type_e ls);
        logic [63:0] actual;
        access(1'b0, `RAM_BASE + 64'(ofs), ls, 64'd0, actual);
        check_value(what, expect_load(ofs, ls), actual);
    endtask

    task automatic plic_read_check(input string what, input logic [63:0] addr,
                                   input logic [31:0] expected);
        logic [63:0] actual;
        access(1'b0, addr, LS_WU, 64'd0, actual);
        check_value(what, {32'd0, expected}, actual);
    endtask

    task automatic plic_write(input logic [63:0] addr, input logic [31:0] value);
        logic [63:0] unused;
        access(1'b1, addr, LS_W, {32'd0, value}, unused);
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_start);
            failed_tests++;
        end
    endtask

    task automatic word_test();
        int unsigned ofs;
        start_test("word_access");
        for (int unsigned n = 0; n < 8; n++) begin
            ofs = 4 * ($urandom % `RAM_WORDS);
            // alternate the sign bit so both extensions show
            store(ofs, LS_W, {32'd0, n[0], 31'($urandom)});
            load_check("lw", ofs, LS_W);
            load_check("lwu", ofs, LS_WU);
        end
        end_test();
    endtask

    task automatic byte_half_test();
        int unsigned base;
        base = 4 * 64;
        start_test("byte_halfword");
        store(base, LS_W, {32'd0, $urandom});
        for (int unsigned k = 0; k < 4; k++) begin
            store(base + k, LS_B, {56'd0, k[0], 7'($urandom)});
            load_check("lw after sb", base, LS_W);
        end
        for (int unsigned k = 0; k < 4; k++) begin
            load_check("lb", base + k, LS_B);
            load_check("lbu", base + k, LS_BU);
        end
        for (int unsigned k = 0; k < 4; k += 2) begin
            store(base + k, LS_H, {48'd0, !k[1], 15'($urandom)});
            load_check("lw after sh", base, LS_W);
        end
        for (int unsigned k = 0; k < 4; k += 2) begin
            load_check("lh", base + k, LS_H);
            load_check("lhu", base + k, LS_HU);
        end
        end_test();
    endtask

    task automatic double_test();
        start_test("doubleword");
        store(4 * 128, LS_D, {$urandom, $urandom});
        load_check("ld after sd", 4 * 128, LS_D);
        store(4 * 200, LS_W, {32'd0, $urandom});
        store(4 * 201, LS_W, {32'd0, $urandom});
        load_check("ld over two sw", 4 * 200, LS_D);
        end_test();
    endtask

    task automatic irq_test();
        start_test("interrupts");
        plic_write(ENABLE0_ADDR, SOURCE_BIT);
        plic_read_check("enable0 readback", ENABLE0_ADDR, SOURCE_BIT);
        check_value("meip before edge", 64'd0, {63'd0, meip_interrupt});
        @(posedge clock_slow);
        irq_source <= 1'b1;
        for (int c = 0; c < 10 && !meip_interrupt; c++) begin
            @(negedge clock_slow);
        end
        check_value("meip after edge", 64'd1, {63'd0, meip_interrupt});
        check_value("msip with ctx1 off", 64'd0, {63'd0, msip_interrupt});
        plic_write(ENABLE1_ADDR, SOURCE_BIT);
        check_value("msip with ctx1 on", 64'd1, {63'd0, msip_interrupt});
        plic_read_check("pending before claim", PENDING_ADDR, SOURCE_BIT);
        plic_read_check("claim0", CLAIM0_ADDR, `IRQ_SOURCE_ID);
        check_value("meip after claim", 64'd0, {63'd0, meip_interrupt});
        check_value("msip after claim", 64'd0, {63'd0, msip_interrupt});
        plic_read_check("pending after claim", PENDING_ADDR, 32'd0);
        plic_read_check("second claim0", CLAIM0_ADDR, 32'd0);
        @(posedge clock_slow);
        irq_source <= 1'b0;
        end_test();
    endtask

    task automatic unmapped_test();
        logic [63:0] actual;
        start_test("unmapped");
        store(0, LS_W, {32'd0, 1'b1, 31'($urandom)});
        // leaves non-zero data on the read bus
        load_check("ram word 0", 0, LS_W);
        access(1'b0, UNMAPPED_ADDR, LS_D, 64'd0, actual);
        check_value("unmapped read", 64'd0, actual);
        access(1'b1, UNMAPPED_ADDR, LS_W, {$urandom, $urandom}, actual);
        // one past the RAM would alias word 0 if the decode dropped the top bits
        access(1'b1, `RAM_BASE + 64'(RAM_BYTES), LS_W, {$urandom, $urandom}, actual);
        load_check("ram word 0 after writes", 0, LS_W);
        load_check("byte_halfword word", 4 * 64, LS_W);
        access(1'b0, `RAM_BASE + 64'(RAM_BYTES), LS_W, 64'd0, actual);
        check_value("read past ram", 64'd0, actual);
        end_test();
    endtask

    initial begin
        int total_errors;
        void'($urandom(32'h188c));
        bus_address      <= 64'd0;
        bus_write_data   <= 64'd0;
        bus_read_enable  <= 1'b0;
        bus_write_enable <= 1'b0;
        bus_ls_type      <= LS_W;
        irq_source       <= 1'b0;
        @(posedge KEY0);
        word_test();
        byte_half_test();
        double_test();
        irq_test();
        unmapped_test();
        total_errors = errors + int'(dut.props.fail_count);
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 NUM_TESTS, failed_tests, errors, dut.props.fail_count);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // generous bound on total run length
    initial begin
        repeat (NUM_TESTS * MAX_REQUESTS * ACCESS_TIMEOUT + RESET_CYCLES) @(posedge clock_slow);
        $display("watchdog expired before all tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/bus_pkg.sv
source/bus_ifs.sv
source/bus_access_sequencer.sv
source/word_ram.sv
source/load_formatter.sv
source/interrupt_controller.sv
source/memory_subsystem.sv
testbench/tb_clock_gen.sv
testbench/memory_subsystem_props.sv
testbench/memory_subsystem_tb.sv

// File: Makefile
TOP = memory_subsystem_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
